// File: common/tcm_pkg.sv
// Address map, widths and enums that the TCM RTL and testbench import by wildcard

package tcm_pkg;

    // ------------------------------------------------------------------
    // Data path widths
    // ------------------------------------------------------------------
    localparam int unsigned XLEN   = 32;
    localparam int unsigned STRB_W = XLEN / 8;

    // ------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------
    // Instruction TCM window, 4 KiB
    localparam logic [XLEN-1:0] ITCM_BASE = 32'h0001_0000;
    localparam int unsigned     ITCM_SIZE = 4096;

    // Data TCM window, 4 KiB
    localparam logic [XLEN-1:0] DTCM_BASE = 32'h0002_0000;
    localparam int unsigned     DTCM_SIZE = 4096;

    // Words per bank
    localparam int unsigned ITCM_DEPTH = ITCM_SIZE / STRB_W;
    localparam int unsigned DTCM_DEPTH = DTCM_SIZE / STRB_W;

    // Word index sized for the deeper of the two banks
    localparam int unsigned BANK_AW = (ITCM_DEPTH > DTCM_DEPTH) ?
                                      $clog2(ITCM_DEPTH) : $clog2(DTCM_DEPTH);

    // ------------------------------------------------------------------
    // Enums
    // ------------------------------------------------------------------
    // Result of decoding a request address
    typedef enum logic [1:0] {
        REGION_ITCM = 2'd0,
        REGION_DTCM = 2'd1,
        REGION_NONE = 2'd2
    } region_e;

    // Which requester owns an access
    typedef enum logic {
        OWNER_CORE = 1'b0,
        OWNER_EXT  = 1'b1
    } owner_e;

endpackage

// File: common/mem_port_if.sv
// Level req/ack memory port between a requester and the TCM pipeline, one instance per port

`timescale 1ns/100ps

interface mem_port_if import tcm_pkg::*; ();

    // Request side, held steady until ack
    logic              req;
    logic              we;
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   wdata;
    logic [STRB_W-1:0] strb;

    // Response side, valid only while ack is high
    logic              ack;
    logic              error;
    logic [XLEN-1:0]   rdata;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        output strb,
        input  ack,
        input  error,
        input  rdata
    );

    modport responder (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        input  strb,
        output ack,
        output error,
        output rdata
    );

endinterface

// File: common/bank_cmd_if.sv
// Per-bank command from the arbiter, read by the RAM bank and the response router

`timescale 1ns/100ps

interface bank_cmd_if import tcm_pkg::*; ();

    logic               en;
    logic               we;
    logic [BANK_AW-1:0] word_addr;
    logic [XLEN-1:0]    wdata;
    logic [STRB_W-1:0]  be;
    owner_e             owner;

    // Registered read data from the bank
    logic [XLEN-1:0]    rdata;

    modport arbiter (
        output en,
        output we,
        output word_addr,
        output wdata,
        output be,
        output owner
    );

    modport bank (
        input  en,
        input  we,
        input  word_addr,
        input  wdata,
        input  be,
        output rdata
    );

    modport router (input en, input owner, input rdata);

endinterface

// File: tcm/tcm_bank.sv
// Single-port TCM bank with byte enables and registered read data, used for ITCM and DTCM

`timescale 1ns/100ps

module tcm_bank import tcm_pkg::*; #(
    parameter int unsigned DEPTH = ITCM_DEPTH
) (
    input  logic     clk_i,
    bank_cmd_if.bank cmd
);

    logic [XLEN-1:0] mem [DEPTH];

    // ------------------------------------------------------------------
    // Access
    // ------------------------------------------------------------------
    // Read data is the word before any write in the same cycle
    always_ff @(posedge clk_i) begin
        if (cmd.en) begin
            cmd.rdata <= mem[cmd.word_addr];
            if (cmd.we) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (cmd.be[b]) begin
                        mem[cmd.word_addr][b*8 +: 8] <= cmd.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: verilog/tcm_arbiter.sv
// Address decode and bank arbitration, issuing at most one command per bank each cycle

`timescale 1ns/100ps

module tcm_arbiter import tcm_pkg::*; (
    input  logic          clk_i,
    input  logic          reset_i,
    mem_port_if.responder core_port,
    mem_port_if.responder ext_port,
    bank_cmd_if.arbiter   itcm_cmd,
    bank_cmd_if.arbiter   dtcm_cmd,
    output logic          core_reject_o,
    output logic          ext_reject_o
);

    region_e            core_region;
    region_e            ext_region;
    logic [BANK_AW-1:0] core_windex;
    logic [BANK_AW-1:0] ext_windex;
    logic               core_busy_q;
    logic               ext_busy_q;
    logic               core_go;
    logic               ext_go;
    logic               core_itcm;
    logic               core_dtcm;
    logic               ext_itcm;
    logic               ext_dtcm;

    function automatic region_e decode(input logic [XLEN-1:0] addr);
        if (addr >= ITCM_BASE && addr < ITCM_BASE + ITCM_SIZE) begin
            return REGION_ITCM;
        end
        if (addr >= DTCM_BASE && addr < DTCM_BASE + DTCM_SIZE) begin
            return REGION_DTCM;
        end
        return REGION_NONE;
    endfunction

    // Byte offset into the window, then drop the byte lanes
    function automatic logic [BANK_AW-1:0] word_index(input logic [XLEN-1:0] addr,
                                                      input region_e region);
        logic [XLEN-1:0] offset;
        offset = (region == REGION_DTCM) ? addr - DTCM_BASE : addr - ITCM_BASE;
        return offset[BANK_AW+1:2];
    endfunction

    assign core_region = decode(core_port.addr);
    assign ext_region  = decode(ext_port.addr);
    assign core_windex = word_index(core_port.addr, core_region);
    assign ext_windex  = word_index(ext_port.addr, ext_region);

    // ------------------------------------------------------------------
    // Grants
    // ------------------------------------------------------------------
    // A port with a response in flight sits out one cycle
    assign core_go = core_port.req && !core_busy_q;
    assign ext_go  = ext_port.req && !ext_busy_q;

    // Core has priority on a shared bank
    assign core_itcm = core_go && (core_region == REGION_ITCM);
    assign core_dtcm = core_go && (core_region == REGION_DTCM);
    assign ext_itcm  = ext_go && (ext_region == REGION_ITCM) && !core_itcm;
    assign ext_dtcm  = ext_go && (ext_region == REGION_DTCM) && !core_dtcm;

    assign core_reject_o = core_go && (core_region == REGION_NONE);
    assign ext_reject_o  = ext_go && (ext_region == REGION_NONE);

    // ------------------------------------------------------------------
    // Bank commands
    // ------------------------------------------------------------------
    assign itcm_cmd.en        = core_itcm || ext_itcm;
    assign itcm_cmd.owner     = core_itcm ? OWNER_CORE : OWNER_EXT;
    assign itcm_cmd.we        = core_itcm ? core_port.we : ext_port.we;
    assign itcm_cmd.word_addr = core_itcm ? core_windex : ext_windex;
    assign itcm_cmd.wdata     = core_itcm ? core_port.wdata : ext_port.wdata;
    assign itcm_cmd.be        = core_itcm ? core_port.strb : ext_port.strb;

    assign dtcm_cmd.en        = core_dtcm || ext_dtcm;
    assign dtcm_cmd.owner     = core_dtcm ? OWNER_CORE : OWNER_EXT;
    assign dtcm_cmd.we        = core_dtcm ? core_port.we : ext_port.we;
    assign dtcm_cmd.word_addr = core_dtcm ? core_windex : ext_windex;
    assign dtcm_cmd.wdata     = core_dtcm ? core_port.wdata : ext_port.wdata;
    assign dtcm_cmd.be        = core_dtcm ? core_port.strb : ext_port.strb;

    // In-flight flags, set for the cycle in which the ack returns
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            core_busy_q <= 1'b0;
            ext_busy_q  <= 1'b0;
        end else begin
            core_busy_q <= core_itcm || core_dtcm || core_reject_o;
            ext_busy_q  <= ext_itcm || ext_dtcm || ext_reject_o;
        end
    end

endmodule

// File: verilog/response_router.sv
// Returns ack, error and read data to the port that owned each access, one cycle after issue

`timescale 1ns/100ps

module response_router import tcm_pkg::*; (
    input  logic          clk_i,
    input  logic          reset_i,
    bank_cmd_if.router    itcm_cmd,
    bank_cmd_if.router    dtcm_cmd,
    input  logic          core_reject_i,
    input  logic          ext_reject_i,
    mem_port_if.responder core_port,
    mem_port_if.responder ext_port
);

    logic   itcm_vld_q;
    logic   dtcm_vld_q;
    owner_e itcm_own_q;
    owner_e dtcm_own_q;
    logic   core_rej_q;
    logic   ext_rej_q;
    logic   core_itcm_hit;
    logic   core_dtcm_hit;
    logic   ext_itcm_hit;
    logic   ext_dtcm_hit;

    // ------------------------------------------------------------------
    // Issue tracking
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            itcm_vld_q <= 1'b0;
            dtcm_vld_q <= 1'b0;
            itcm_own_q <= OWNER_CORE;
            dtcm_own_q <= OWNER_CORE;
            core_rej_q <= 1'b0;
            ext_rej_q  <= 1'b0;
        end else begin
            itcm_vld_q <= itcm_cmd.en;
            dtcm_vld_q <= dtcm_cmd.en;
            itcm_own_q <= itcm_cmd.owner;
            dtcm_own_q <= dtcm_cmd.owner;
            core_rej_q <= core_reject_i;
            ext_rej_q  <= ext_reject_i;
        end
    end

    // Which bank answers which port this cycle
    assign core_itcm_hit = itcm_vld_q && (itcm_own_q == OWNER_CORE);
    assign core_dtcm_hit = dtcm_vld_q && (dtcm_own_q == OWNER_CORE);
    assign ext_itcm_hit  = itcm_vld_q && (itcm_own_q == OWNER_EXT);
    assign ext_dtcm_hit  = dtcm_vld_q && (dtcm_own_q == OWNER_EXT);

    // ------------------------------------------------------------------
    // Responses
    // ------------------------------------------------------------------
    // Rejected accesses carry zero read data
    assign core_port.ack   = core_itcm_hit || core_dtcm_hit || core_rej_q;
    assign core_port.error = core_rej_q;
    assign core_port.rdata = core_itcm_hit ? itcm_cmd.rdata :
                             core_dtcm_hit ? dtcm_cmd.rdata : '0;

    assign ext_port.ack    = ext_itcm_hit || ext_dtcm_hit || ext_rej_q;
    assign ext_port.error  = ext_rej_q;
    assign ext_port.rdata  = ext_itcm_hit ? itcm_cmd.rdata :
                             ext_dtcm_hit ? dtcm_cmd.rdata : '0;

endmodule

// File: verilog/tcm_subsystem.sv
// TCM subsystem top level, serving the core data port and the external access port

`timescale 1ns/100ps

module tcm_subsystem import tcm_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,

    // Core data port
    input  logic              core_req_i,
    input  logic              core_we_i,
    input  logic [XLEN-1:0]   core_addr_i,
    input  logic [XLEN-1:0]   core_wdata_i,
    input  logic [STRB_W-1:0] core_strb_i,
    output logic              core_ack_o,
    output logic              core_error_o,
    output logic [XLEN-1:0]   core_rdata_o,

    // External access port
    input  logic              ext_req_i,
    input  logic              ext_we_i,
    input  logic [XLEN-1:0]   ext_addr_i,
    input  logic [XLEN-1:0]   ext_wdata_i,
    input  logic [STRB_W-1:0] ext_strb_i,
    output logic              ext_ack_o,
    output logic              ext_error_o,
    output logic [XLEN-1:0]   ext_rdata_o
);

    mem_port_if core_port ();
    mem_port_if ext_port ();
    bank_cmd_if itcm_cmd ();
    bank_cmd_if dtcm_cmd ();

    logic core_reject;
    logic ext_reject;

    // ------------------------------------------------------------------
    // Plain ports onto the port interfaces
    // ------------------------------------------------------------------
    assign core_port.req   = core_req_i;
    assign core_port.we    = core_we_i;
    assign core_port.addr  = core_addr_i;
    assign core_port.wdata = core_wdata_i;
    assign core_port.strb  = core_strb_i;
    assign core_ack_o      = core_port.ack;
    assign core_error_o    = core_port.error;
    assign core_rdata_o    = core_port.rdata;

    assign ext_port.req    = ext_req_i;
    assign ext_port.we     = ext_we_i;
    assign ext_port.addr   = ext_addr_i;
    assign ext_port.wdata  = ext_wdata_i;
    assign ext_port.strb   = ext_strb_i;
    assign ext_ack_o       = ext_port.ack;
    assign ext_error_o     = ext_port.error;
    assign ext_rdata_o     = ext_port.rdata;

    // ------------------------------------------------------------------
    // Decode and arbitration, bank access, response routing
    // ------------------------------------------------------------------
    tcm_arbiter u_arbiter (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .core_port     (core_port),
        .ext_port      (ext_port),
        .itcm_cmd      (itcm_cmd),
        .dtcm_cmd      (dtcm_cmd),
        .core_reject_o (core_reject),
        .ext_reject_o  (ext_reject)
    );

    tcm_bank #(.DEPTH(ITCM_DEPTH)) u_itcm (.clk_i(clk_i), .cmd(itcm_cmd));
    tcm_bank #(.DEPTH(DTCM_DEPTH)) u_dtcm (.clk_i(clk_i), .cmd(dtcm_cmd));

    response_router u_router (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .itcm_cmd      (itcm_cmd),
        .dtcm_cmd      (dtcm_cmd),
        .core_reject_i (core_reject),
        .ext_reject_i  (ext_reject),
        .core_port     (core_port),
        .ext_port      (ext_port)
    );

endmodule

// File: bench/tcm_properties.sv
// Concurrent assertions on the req/ack handshake, bound onto the TCM subsystem top level

`timescale 1ns/100ps

module tcm_properties (
    input logic clk_i,
    input logic reset_i,
    input logic core_req_i,
    input logic core_ack_i,
    input logic ext_req_i,
    input logic ext_ack_i
);

    // Count of failed assertions
    int unsigned fail_cnt = 0;

    // ----------------------------------------------------------------------
    // Ack is a single-cycle pulse
    // ----------------------------------------------------------------------
    core_ack_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        core_ack_i |=> !core_ack_i)
        else begin
            $error("core ack high for more than one cycle");
            fail_cnt++;
        end

    ext_ack_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
        ext_ack_i |=> !ext_ack_i)
        else begin
            $error("ext ack high for more than one cycle");
            fail_cnt++;
        end

    // ----------------------------------------------------------------------
    // Ack only answers a request
    // ----------------------------------------------------------------------
    // Requester may drop req as soon as it sees ack, so look at the issue cycle
    core_ack_has_req: assert property (@(posedge clk_i) disable iff (reset_i)
        core_ack_i |-> $past(core_req_i))
        else begin
            $error("core ack without a core request");
            fail_cnt++;
        end

    ext_ack_has_req: assert property (@(posedge clk_i) disable iff (reset_i)
        ext_ack_i |-> $past(ext_req_i))
        else begin
            $error("ext ack without an ext request");
            fail_cnt++;
        end

    // Core always wins its bank, so its latency is fixed
    core_ack_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(core_req_i) |=> core_ack_i)
        else begin
            $error("core ack did not follow core req after one cycle");
            fail_cnt++;
        end

endmodule

// File: bench/tb_tcm_subsystem.sv
// Testbench that drives both TCM subsystem ports and checks every ack against a memory model

`timescale 1ns/100ps

module tb_tcm_subsystem import tcm_pkg::*; ();

    typedef struct packed {
        logic              ext;
        logic              we;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] strb;
        logic              error;
        logic [XLEN-1:0]   rdata;
    } resp_t;

    // Random test is the longest at about 300 cycles for 200 accesses
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RAND_N         = 100;

    logic              clk_i;
    logic              reset_i;
    logic              core_req_i;
    logic              core_we_i;
    logic [XLEN-1:0]   core_addr_i;
    logic [XLEN-1:0]   core_wdata_i;
    logic [STRB_W-1:0] core_strb_i;
    logic              core_ack_o;
    logic              core_error_o;
    logic [XLEN-1:0]   core_rdata_o;
    logic              ext_req_i;
    logic              ext_we_i;
    logic [XLEN-1:0]   ext_addr_i;
    logic [XLEN-1:0]   ext_wdata_i;
    logic [STRB_W-1:0] ext_strb_i;
    logic              ext_ack_o;
    logic              ext_error_o;
    logic [XLEN-1:0]   ext_rdata_o;

    // Reference memories sized like the banks
    logic [XLEN-1:0]   itcm_ref [ITCM_DEPTH];
    logic [XLEN-1:0]   dtcm_ref [DTCM_DEPTH];
    resp_t             resp_q [$];
    int                err_cnt = 0;
    int                check_cnt = 0;
    int                test_num = 0;
    int                tests_failed = 0;
    int                cycle_cnt = 0;
    int                core_lat;
    int                ext_lat;
    integer            seed;

    tcm_subsystem u_dut (.*);

    bind tcm_subsystem tcm_properties u_props (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .core_req_i (core_req_i),
        .core_ack_i (core_ack_o),
        .ext_req_i  (ext_req_i),
        .ext_ack_i  (ext_ack_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a request never got its ack", cycle_cnt);
            $display("Finished with errors");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Reference model and checking
    // ----------------------------------------------------------------------
    // Returns {error, rdata} with the word as it was before any write
    function automatic logic [XLEN:0] ref_access(input logic we, input logic [XLEN-1:0] addr,
                                                 input logic [XLEN-1:0] wdata,
                                                 input logic [STRB_W-1:0] strb);
        logic            in_itcm;
        logic            in_dtcm;
        int              idx;
        logic [XLEN-1:0] old;
        logic [XLEN-1:0] merged;
        in_itcm = (addr >= ITCM_BASE) && (addr - ITCM_BASE < ITCM_SIZE);
        in_dtcm = (addr >= DTCM_BASE) && (addr - DTCM_BASE < DTCM_SIZE);
        if (!in_itcm && !in_dtcm) begin
            return {1'b1, {XLEN{1'b0}}};
        end
        idx    = in_itcm ? int'((addr - ITCM_BASE) >> 2) : int'((addr - DTCM_BASE) >> 2);
        old    = in_itcm ? itcm_ref[idx] : dtcm_ref[idx];
        merged = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (we && strb[b]) begin
                merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        if (in_itcm) begin
            itcm_ref[idx] = merged;
        end else begin
            dtcm_ref[idx] = merged;
        end
        return {1'b0, old};
    endfunction

    task automatic check(input string name, input logic [XLEN-1:0] expected,
                         input logic [XLEN-1:0] actual);
        check_cnt++;
        if (actual !== expected) begin
            err_cnt++;
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Responses are applied to the model in ack order
    always @(posedge clk_i) begin
        resp_t         r;
        logic [XLEN:0] exp;
        while (resp_q.size() > 0) begin
            r   = resp_q.pop_front();
            exp = ref_access(r.we, r.addr, r.wdata, r.strb);
            check(r.ext ? "ext_error_o" : "core_error_o", XLEN'(exp[XLEN]), XLEN'(r.error));
            check(r.ext ? "ext_rdata_o" : "core_rdata_o", exp[XLEN-1:0], r.rdata);
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    // One request on one port held until its ack
    task automatic drive_access(input logic is_ext, input logic we, input logic [XLEN-1:0] addr,
                                input logic [XLEN-1:0] wdata, input logic [STRB_W-1:0] strb);
        int lat;
        lat = 0;
        @(negedge clk_i);
        if (is_ext) begin
            ext_req_i   = 1'b1;
            ext_we_i    = we;
            ext_addr_i  = addr;
            ext_wdata_i = wdata;
            ext_strb_i  = strb;
        end else begin
            core_req_i   = 1'b1;
            core_we_i    = we;
            core_addr_i  = addr;
            core_wdata_i = wdata;
            core_strb_i  = strb;
        end
        do begin
            @(negedge clk_i);
            lat++;
        end while (!(is_ext ? ext_ack_o : core_ack_o));
        if (is_ext) begin
            resp_q.push_back(resp_t'{1'b1, we, addr, wdata, strb, ext_error_o, ext_rdata_o});
            ext_req_i = 1'b0;
            ext_lat   = lat;
        end else begin
            resp_q.push_back(resp_t'{1'b0, we, addr, wdata, strb, core_error_o, core_rdata_o});
            core_req_i = 1'b0;
            core_lat   = lat;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        @(posedge clk_i);
        @(negedge clk_i);
        test_num++;
        if (err_cnt == errs_before) begin
            $display("Test %0d %s: pass", test_num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: fail, %0d errors", test_num, name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int              errs;
        int              total_errs;
        int              sel;
        logic            rnd_we [2][RAND_N];
        logic [XLEN-1:0] rnd_addr [2][RAND_N];
        logic [XLEN-1:0] rnd_wdata [2][RAND_N];
        logic [STRB_W-1:0] rnd_strb [2][RAND_N];
        seed         = 32'h2e76;
        reset_i      = 1'b1;
        core_req_i   = 1'b0;
        core_we_i    = 1'b0;
        core_addr_i  = '0;
        core_wdata_i = '0;
        core_strb_i  = '0;
        ext_req_i    = 1'b0;
        ext_we_i     = 1'b0;
        ext_addr_i   = '0;
        ext_wdata_i  = '0;
        ext_strb_i   = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        errs = err_cnt;
        drive_access(1'b0, 1'b1, DTCM_BASE + 32'h40, 32'h1122_3344, 4'hf);
        check("core_ack_o delay", 1, core_lat);
        drive_access(1'b0, 1'b1, DTCM_BASE + 32'h40, 32'haabb_ccdd, 4'b0101);
        check("core_ack_o delay", 1, core_lat);
        drive_access(1'b0, 1'b0, DTCM_BASE + 32'h40, '0, 4'hf);
        check("core_ack_o delay", 1, core_lat);
        end_test("core partial write to DTCM", errs);

        errs = err_cnt;
        drive_access(1'b1, 1'b1, ITCM_BASE + 32'h80, 32'hcafe_f00d, 4'hf);
        drive_access(1'b0, 1'b0, ITCM_BASE + 32'h80, '0, 4'hf);
        end_test("ext write then core read of ITCM", errs);

        errs = err_cnt;
        drive_access(1'b0, 1'b1, ITCM_BASE, 32'h5a5a_0001, 4'hf);
        drive_access(1'b1, 1'b1, DTCM_BASE, 32'h5a5a_0002, 4'hf);
        drive_access(1'b0, 1'b1, ITCM_BASE + ITCM_SIZE, 32'hdead_beef, 4'hf);
        drive_access(1'b1, 1'b1, DTCM_BASE + DTCM_SIZE, 32'hdead_beef, 4'hf);
        drive_access(1'b1, 1'b0, 32'h0000_0000, '0, 4'hf);
        drive_access(1'b0, 1'b0, ITCM_BASE, '0, 4'hf);
        drive_access(1'b1, 1'b0, DTCM_BASE, '0, 4'hf);
        end_test("out-of-window accesses", errs);

        errs = err_cnt;
        fork
            drive_access(1'b0, 1'b1, DTCM_BASE + 32'h100, 32'h0101_0101, 4'hf);
            drive_access(1'b1, 1'b1, DTCM_BASE + 32'h100, 32'h0202_0202, 4'h3);
        join
        check("core_ack_o delay", 1, core_lat);
        // Ext loses the first cycle to the core, then issues
        check("ext_ack_o delay", 2, ext_lat);
        drive_access(1'b0, 1'b0, DTCM_BASE + 32'h100, '0, 4'hf);
        end_test("same-bank conflict", errs);

        errs = err_cnt;
        fork
            drive_access(1'b0, 1'b0, ITCM_BASE + 32'h80, '0, 4'hf);
            drive_access(1'b1, 1'b1, DTCM_BASE + 32'h40, 32'h7777_8888, 4'hc);
        join
        check("core_ack_o delay", 1, core_lat);
        check("ext_ack_o delay", 1, ext_lat);
        end_test("different banks in parallel", errs);

        // Stimulus drawn before the fork so both ports see a fixed sequence
        errs = err_cnt;
        for (int p = 0; p < 2; p++) begin
            for (int i = 0; i < RAND_N; i++) begin
                sel = $random(seed) & 3;
                rnd_addr[p][i] = (sel == 0) ? ITCM_BASE : (sel == 1) ? DTCM_BASE :
                                 (sel == 2) ? DTCM_BASE + DTCM_SIZE : ITCM_BASE + ITCM_SIZE;
                rnd_addr[p][i] = rnd_addr[p][i] + XLEN'(($random(seed) & 15) * 4);
                rnd_we[p][i]    = 1'($random(seed));
                rnd_wdata[p][i] = $random(seed);
                rnd_strb[p][i]  = STRB_W'($random(seed));
            end
        end
        fork
            for (int i = 0; i < RAND_N; i++) begin
                drive_access(1'b0, rnd_we[0][i], rnd_addr[0][i], rnd_wdata[0][i],
                             rnd_strb[0][i]);
            end
            for (int i = 0; i < RAND_N; i++) begin
                drive_access(1'b1, rnd_we[1][i], rnd_addr[1][i], rnd_wdata[1][i],
                             rnd_strb[1][i]);
            end
        join
        end_test("random accesses from both ports", errs);

        total_errs = err_cnt + int'(u_dut.u_props.fail_cnt);
        $display("Tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 test_num, tests_failed, check_cnt, total_errs);
        if (total_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: project.f
common/tcm_pkg.sv
common/mem_port_if.sv
common/bank_cmd_if.sv
tcm/tcm_bank.sv
verilog/tcm_arbiter.sv
verilog/response_router.sv
verilog/tcm_subsystem.sv
bench/tcm_properties.sv
bench/tb_tcm_subsystem.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make help   list these targets"
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_tcm_subsystem \
		-f project.f -o sim_tb
	@out=$$(./obj_dir/sim_tb); echo "$$out"; \
		echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
